/* fxu_defs.svh */
/* Fixed-point unit configuration
   Q16.16 word layout and multiplier latency */
`ifndef FXU_DEFS_SVH
`define FXU_DEFS_SVH

// Word layout, integer part above the fraction
`define FXU_WIDTH      32
`define FXU_INT_WIDTH  16
`define FXU_FRAC_WIDTH 16

// Cycles from the sampled go to the multiplier done
`define FXU_MUL_STAGES 3

`endif

/* fxu_pkg.sv */
/* Fixed-point unit types
   Q16.16 words and the operation codes */
`include "fxu_defs.svh"

package fxu_pkg;

  // Read as signed or unsigned depending on is_signed
  typedef logic [`FXU_WIDTH-1:0] word_t;

  // Full product of two words
  typedef logic [2*`FXU_WIDTH-1:0] dword_t;

  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_lt  = 3'd2,
    op_mul = 3'd3,
    op_div = 3'd4
  } fxu_op_t;

endpackage

/* fxu_unit_if.sv */
/* One operation between the fxu control top and an arithmetic unit
   Level go in, single-cycle done and a held result out */
interface fxu_unit_if import fxu_pkg::*; ();

  logic  go;
  logic  is_signed;
  word_t left;
  word_t right;
  word_t result;
  logic  done;

  modport ctrl (
    output go,
    output is_signed,
    output left,
    output right,
    input  result,
    input  done
  );

  modport unit (
    input  go,
    input  is_signed,
    input  left,
    input  right,
    output result,
    output done
  );

endinterface

/* fxu_addsub_cmp.sv */
/* Registered add, subtract and less-than on Q16.16 words
   Done one cycle after go, re-armed once go drops */
`include "fxu_defs.svh"

module fxu_addsub_cmp import fxu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  fxu_op_t  op,
  fxu_unit_if.unit u
);

  logic go_q;
  logic start;
  logic less;

  // Only the first cycle of a go level starts an operation
  assign start = u.go && !go_q;
  assign less  = u.is_signed ? ($signed(u.left) < $signed(u.right)) : (u.left < u.right);

  always_ff @(posedge clk) begin
    if (rst) begin
      go_q     <= 1'b0;
      u.done   <= 1'b0;
      u.result <= '0;
    end else begin
      go_q   <= u.go;
      u.done <= start;
      if (start) begin
        case (op)
          op_add:  u.result <= u.left + u.right;
          op_sub:  u.result <= u.left - u.right;
          op_lt:   u.result <= {{(`FXU_WIDTH-1){1'b0}}, less};
          default: u.result <= u.result;
        endcase
      end
    end
  end

  a_done_single: assert property (@(posedge clk) disable iff (rst) u.done |=> !u.done);

endmodule

/* fxu_mult_pipe.sv */
/* Three-stage Q16.16 multiplier, signed or unsigned
   Operands, full product, then the middle bits into result */
`include "fxu_defs.svh"

module fxu_mult_pipe import fxu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  fxu_unit_if.unit u
);

  localparam int W = `FXU_WIDTH;
  localparam int S = `FXU_MUL_STAGES;

  word_t        ltmp;
  word_t        rtmp;
  dword_t       lext;
  dword_t       rext;
  dword_t       product;
  logic [S-1:0] chain;
  logic         start;

  // A new operation enters only behind an empty chain
  assign start  = u.go && (chain == '0);
  assign u.done = chain[S-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      chain <= '0;
    end else if (u.go) begin
      chain <= {chain[S-2:0], start};
    end else begin
      chain <= '0;
    end
  end

  // Widen to the product width, sign fill for signed words
  assign lext = u.is_signed ? {{W{ltmp[W-1]}}, ltmp} : {{W{1'b0}}, ltmp};
  assign rext = u.is_signed ? {{W{rtmp[W-1]}}, rtmp} : {{W{1'b0}}, rtmp};

  always_ff @(posedge clk) begin
    if (u.go) begin
      ltmp    <= u.left;
      rtmp    <= u.right;
      product <= lext * rext;
    end
  end

  // Bits 47:16 keep the Q16.16 alignment
  always_ff @(posedge clk) begin
    if (rst) begin
      u.result <= '0;
    end else if (u.go && chain[S-2]) begin
      u.result <= product[2*W-`FXU_INT_WIDTH-1:`FXU_FRAC_WIDTH];
    end
  end

  a_go_held: assert property (@(posedge clk) disable iff (rst)
    u.done |-> $past(u.go, 1) && $past(u.go, 2) && $past(u.go, 3));

endmodule

/* fxu_div_iter.sv */
/* Unsigned restoring Q16.16 divider, one quotient bit per cycle
   Zero dividend or divisor finishes in one cycle with quotient 0 */
`include "fxu_defs.svh"

module fxu_div_iter import fxu_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  go,
  input  word_t dividend,
  input  word_t divisor,
  output word_t quotient,
  output logic  done
);

  localparam int W     = `FXU_WIDTH;
  localparam int ITERS = `FXU_WIDTH + `FXU_FRAC_WIDTH;
  localparam int IDX_W = $clog2(ITERS);

  logic [IDX_W-1:0] idx;
  logic             running;
  logic             spent;
  logic             start;
  logic             trivial;
  logic             finished;
  word_t            acc;
  word_t            acc_cur;
  word_t            acc_next;
  word_t            shreg;
  word_t            shreg_cur;
  word_t            quo;
  word_t            quo_cur;
  word_t            quo_next;
  logic [W:0]       shifted;
  logic [W:0]       diff;
  logic             fits;

  assign start    = go && !running && !spent;
  assign trivial  = start && (dividend == '0 || divisor == '0);
  assign finished = running && go && (idx == IDX_W'(ITERS - 1));

  // The first step is taken in the start cycle itself
  assign acc_cur   = start ? '0 : acc;
  assign shreg_cur = start ? dividend : shreg;
  assign quo_cur   = start ? '0 : quo;

  // Shift in the next dividend bit, zeros once the dividend is used up
  assign shifted  = {acc_cur, shreg_cur[W-1]};
  assign diff     = shifted - {1'b0, divisor};
  assign fits     = shifted >= {1'b0, divisor};
  assign acc_next = fits ? diff[W-1:0] : shifted[W-1:0];
  assign quo_next = {quo_cur[W-2:0], fits};

  always_ff @(posedge clk) begin
    if (start || running) begin
      acc   <= acc_next;
      shreg <= {shreg_cur[W-2:0], 1'b0};
      quo   <= quo_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      running  <= 1'b0;
      spent    <= 1'b0;
      idx      <= '0;
      done     <= 1'b0;
      quotient <= '0;
    end else begin
      done <= trivial || finished;
      if (!go) begin
        running <= 1'b0;
        spent   <= 1'b0;
      end else if (trivial || finished) begin
        running <= 1'b0;
        spent   <= 1'b1;
      end else if (start) begin
        running <= 1'b1;
      end
      if (start) begin
        idx <= IDX_W'(1);
      end else if (running) begin
        idx <= idx + 1'b1;
      end else begin
        idx <= '0;
      end
      if (trivial) begin
        quotient <= '0;
      end else if (finished) begin
        quotient <= quo_next;
      end
    end
  end

  a_done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done);

endmodule

/* fxu_sdiv.sv */
/* Signed wrapper around the unsigned Q16.16 divider
   Divides magnitudes and negates the quotient on differing signs */
`include "fxu_defs.svh"

module fxu_sdiv import fxu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  fxu_unit_if.unit u
);

  localparam int W = `FXU_WIDTH;

  word_t left_mag;
  word_t right_mag;
  word_t quo_mag;
  word_t quo_signed;
  word_t quo_held;
  logic  neg;
  logic  neg_q;

  // Unsigned operation passes the words through untouched
  assign left_mag  = (u.is_signed && u.left[W-1])  ? -u.left  : u.left;
  assign right_mag = (u.is_signed && u.right[W-1]) ? -u.right : u.right;
  assign neg       = u.is_signed && (u.left[W-1] ^ u.right[W-1]);

  // Sign of the running operation
  always_ff @(posedge clk) begin
    if (rst) begin
      neg_q <= 1'b0;
    end else if (u.go) begin
      neg_q <= neg;
    end
  end

  fxu_div_iter div_i (
    .clk      (clk),
    .rst      (rst),
    .go       (u.go),
    .dividend (left_mag),
    .divisor  (right_mag),
    .quotient (quo_mag),
    .done     (u.done)
  );

  // Negating the magnitude truncates toward zero
  assign quo_signed = neg_q ? -quo_mag : quo_mag;

  // The last quotient stays visible while the next division runs
  always_ff @(posedge clk) begin
    if (rst) begin
      quo_held <= '0;
    end else if (u.done) begin
      quo_held <= quo_signed;
    end
  end

  assign u.result = u.done ? quo_signed : quo_held;

endmodule

/* fxu_top.sv */
/* Fixed-point arithmetic unit top
   Decodes op, steers go to one unit and selects its result */
module fxu_top import fxu_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    go,
  input  fxu_op_t op,
  input  logic    is_signed,
  input  word_t   left,
  input  word_t   right,
  output word_t   result,
  output logic    done
);

  fxu_unit_if simple_if ();
  fxu_unit_if mul_if ();
  fxu_unit_if div_if ();

  logic sel_simple;
  logic sel_mul;
  logic sel_div;

  assign sel_simple = (op == op_add) || (op == op_sub) || (op == op_lt);
  assign sel_mul    = (op == op_mul);
  assign sel_div    = (op == op_div);

  // Only the selected unit sees go
  assign simple_if.go = go && sel_simple;
  assign mul_if.go    = go && sel_mul;
  assign div_if.go    = go && sel_div;

  // Operands are shared by all units
  assign simple_if.is_signed = is_signed;
  assign simple_if.left      = left;
  assign simple_if.right     = right;
  assign mul_if.is_signed    = is_signed;
  assign mul_if.left         = left;
  assign mul_if.right        = right;
  assign div_if.is_signed    = is_signed;
  assign div_if.left         = left;
  assign div_if.right        = right;

  fxu_addsub_cmp simple_i (
    .clk (clk),
    .rst (rst),
    .op  (op),
    .u   (simple_if.unit)
  );

  fxu_mult_pipe mul_i (
    .clk (clk),
    .rst (rst),
    .u   (mul_if.unit)
  );

  fxu_sdiv div_i (
    .clk (clk),
    .rst (rst),
    .u   (div_if.unit)
  );

  always_comb begin
    if (sel_simple) begin
      result = simple_if.result;
      done   = simple_if.done;
    end else if (sel_mul) begin
      result = mul_if.result;
      done   = mul_if.done;
    end else if (sel_div) begin
      result = div_if.result;
      done   = div_if.done;
    end else begin
      // Spare opcodes never complete
      result = '0;
      done   = 1'b0;
    end
  end

endmodule

/* tb_clock_gen.sv */
/* Testbench clock and reset
   4 ns clock, reset held for the first 10 cycles */
module tb_clock_gen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* tb_fxu_top.sv */
/* Testbench for the fixed-point unit
   LFSR operands, reference model in concurrent assertions, watchdog */
`include "fxu_defs.svh"

module tb_fxu_top import fxu_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS    = 26;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_WAIT     = 60;

  logic    clk;
  logic    rst;
  logic    go;
  fxu_op_t op;
  logic    is_signed;
  word_t   left;
  word_t   right;
  word_t   result;
  logic    done;
  logic    started;
  int      cyc;
  int      errors;
  int      passed;
  int      failed;
  logic [31:0] lfsr_state;
  word_t   a;
  word_t   b;

  tb_clock_gen clk_gen_i (.clk(clk), .rst(rst));

  fxu_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .go        (go),
    .op        (op),
    .is_signed (is_signed),
    .left      (left),
    .right     (right),
    .result    (result),
    .done      (done)
  );

  function automatic logic [31:0] lfsr_next(logic [31:0] st);
    return st[0] ? ((st >> 1) ^ 32'hA300_0000) : (st >> 1);
  endfunction

  // Q16.16 reference, quotient truncated toward zero
  function automatic word_t expected_result(fxu_op_t o, logic s, word_t x, word_t y);
    longint          sp;
    longint unsigned up;
    case (o)
      op_add: return x + y;
      op_sub: return x - y;
      op_lt: begin
        if (s) return word_t'(longint'($signed(x)) < longint'($signed(y)));
        return word_t'(longint'(x) < longint'(y));
      end
      op_mul: begin
        sp = longint'($signed(x)) * longint'($signed(y));
        up = {32'b0, x} * {32'b0, y};
        return s ? sp[47:16] : up[47:16];
      end
      op_div: begin
        if (x == '0 || y == '0) return '0;
        sp = (longint'($signed(x)) * 65536) / longint'($signed(y));
        up = ({32'b0, x} << `FXU_FRAC_WIDTH) / {32'b0, y};
        return s ? sp[31:0] : up[31:0];
      end
      default: return '0;
    endcase
  endfunction

  function automatic int expected_latency(fxu_op_t o, word_t x, word_t y);
    if (o == op_mul) return `FXU_MUL_STAGES;
    if (o == op_div && x != '0 && y != '0) return `FXU_WIDTH + `FXU_FRAC_WIDTH;
    return 1;
  endfunction

  // Cycles since go was first sampled high
  always_ff @(posedge clk) begin
    if (rst || !go) cyc <= 0;
    else cyc <= cyc + 1;
  end

  a_value: assert property (@(posedge clk) disable iff (rst)
    done |-> result == expected_result(op, is_signed, left, right))
    else begin
      errors++;
      $display("CHECK FAILED at %0t: %s result %h, expected %h", $time, op.name(), result,
               expected_result(op, is_signed, left, right));
    end

  a_latency: assert property (@(posedge clk) disable iff (rst)
    done |-> cyc == expected_latency(op, left, right))
    else begin
      errors++;
      $display("CHECK FAILED at %0t: done after %0d cycles for %s", $time, cyc, op.name());
    end

  a_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: done high for two cycles", $time);
    end

  a_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
    !started |-> !done && result == '0)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: output active before the first go", $time);
    end

  a_held: assert property (@(posedge clk) disable iff (rst)
    started && !go |=> go || $stable(result))
    else begin
      errors++;
      $display("CHECK FAILED at %0t: result changed while go was low", $time);
    end

  task automatic draw_bits(input int n, output word_t w);
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
  endtask

  task automatic do_operation(input fxu_op_t o, input logic s, input word_t x, input word_t y);
    int waited;
    int errs_before;
    errs_before = errors;
    @(negedge clk);
    op        = o;
    is_signed = s;
    left      = x;
    right     = y;
    go        = 1'b1;
    started   = 1'b1;
    waited    = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!done && waited < MAX_WAIT);
    if (!done) begin
      errors++;
      $display("No done from the DUT within %0d cycles for %s", MAX_WAIT, o.name());
    end
    go = 1'b0;
    // The assertions sample this result on the next rising edge
    @(negedge clk);
    if (errors == errs_before) passed++;
    else failed++;
    $display("%s signed=%0d left=%h right=%h result=%h %s", o.name(), s, x, y, result,
             (errors == errs_before) ? "pass" : "fail");
  endtask

  initial begin
    go         = 1'b0;
    op         = op_add;
    is_signed  = 1'b0;
    left       = '0;
    right      = '0;
    started    = 1'b0;
    errors     = 0;
    passed     = 0;
    failed     = 0;
    lfsr_state = 32'h792a;
    wait (!rst);
    repeat (3) @(negedge clk);
    for (int s = 0; s < 2; s++) begin
      for (int k = 0; k < 3; k++) begin
        for (int r = 0; r < 2; r++) begin
          draw_bits(32, a);
          draw_bits(32, b);
          // Second compare has opposite sign bits so signedness decides
          if (fxu_op_t'(k) == op_lt && r == 1) b[31] = ~a[31];
          do_operation(fxu_op_t'(k), s[0], a, b);
        end
      end
    end
    // All four sign combinations, then unsigned
    for (int c = 0; c < 4; c++) begin
      draw_bits(32, a);
      draw_bits(32, b);
      a[31] = c[0];
      b[31] = c[1];
      do_operation(op_mul, 1'b1, a, b);
    end
    repeat (2) begin
      draw_bits(32, a);
      draw_bits(32, b);
      do_operation(op_mul, 1'b0, a, b);
    end
    for (int c = 0; c < 4; c++) begin
      draw_bits(32, a);
      draw_bits(20, b);
      a[31] = c[0];
      if (c[1]) b = -b;
      do_operation(op_div, 1'b1, a, b);
    end
    repeat (2) begin
      draw_bits(32, a);
      draw_bits(20, b);
      do_operation(op_div, 1'b0, a, b);
    end
    draw_bits(32, a);
    do_operation(op_div, 1'b1, a, '0);
    draw_bits(32, b);
    do_operation(op_div, 1'b0, '0, b);
    $display("%0d tests passed, %0d failed", passed, failed);
    if (failed == 0 && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (NUM_TESTS * MAX_WAIT + RESET_CYCLES) @(posedge clk);
    $display("Watchdog expired before all operations completed");
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+.
fxu_pkg.sv
fxu_unit_if.sv
fxu_addsub_cmp.sv
fxu_mult_pipe.sv
fxu_div_iter.sv
fxu_sdiv.sv
fxu_top.sv
tb_clock_gen.sv
tb_fxu_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fxu_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(BUILD_DIR)
